/* compile.f */
+incdir+hdl
hdl/alu_pkg.sv
hdl/alu_decode.sv
hdl/alu_execute.sv
hdl/alu_result.sv
hdl/alu_top.sv
verif/alu_checker.sv
verif/alu_tb.sv

/* hdl/alu_decode.sv */
//----------------------------------------------------------------------------
// ALU decode
// Maps opcode and ModRM reg to an ALU op, one register stage
//----------------------------------------------------------------------------
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_decode (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 instr_valid,
	input  logic [7:0]           opcode,
	input  logic [2:0]           modrm_reg,
	input  logic [31:0]          a,
	input  logic [31:0]          b,
	output alu_pkg::decoded_op_t dec
);
	import alu_pkg::*;

	alu_op_e     op_c;
	logic        known_c;
	logic        valid_q;
	logic        illegal_q;
	alu_op_e     op_q;
	logic [31:0] a_q;
	logic [31:0] b_q;

	//------------------------------------------------------------------------
	// Opcode lookup
	always_comb begin
		op_c    = op_add;
		known_c = 1'b1;
		case (opcode)
			`ALU_OP_ADD: op_c = op_add;
			`ALU_OP_OR:  op_c = op_or;
			`ALU_OP_AND: op_c = op_and;
			`ALU_OP_CMP: op_c = op_cmp;
			`ALU_OP_DAA: op_c = op_daa;
			`ALU_OP_CLD: op_c = op_cld;
			`ALU_OP_STD: op_c = op_std;
			`ALU_OP_GRP3: begin
				// Only /2 is supported in group 3
				op_c    = op_not;
				known_c = (modrm_reg == `ALU_MODRM_NOT);
			end
			default: known_c = 1'b0;
		endcase
	end

	//------------------------------------------------------------------------
	// Stage registers
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q   <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			valid_q   <= instr_valid;
			// Illegal only ever rides with valid
			illegal_q <= instr_valid && !known_c;
		end
	end

	// Operands and op, captured on strobe
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			op_q <= op_c;
			a_q  <= a;
			b_q  <= b;
		end
	end

	assign dec = '{valid: valid_q, illegal: illegal_q, op: op_q, a: a_q, b: b_q};

endmodule

/* hdl/alu_defines.svh */
//----------------------------------------------------------------------------
// ALU defines
// Opcode bytes, ModRM selector and EFLAGS layout constants
//----------------------------------------------------------------------------
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

//----------------------------------------------------------------------------
// One-byte opcodes, 32-bit operand forms
`define ALU_OP_ADD    8'h01
`define ALU_OP_OR     8'h09
`define ALU_OP_AND    8'h21
`define ALU_OP_CMP    8'h39
`define ALU_OP_DAA    8'h27
`define ALU_OP_CLD    8'hFC
`define ALU_OP_STD    8'hFD
// Group 3, op picked by ModRM reg
`define ALU_OP_GRP3   8'hF7
`define ALU_MODRM_NOT 3'd2

//----------------------------------------------------------------------------
// EFLAGS bit positions
`define EFLAGS_CF_BIT 0
`define EFLAGS_PF_BIT 2
`define EFLAGS_AF_BIT 4
`define EFLAGS_ZF_BIT 6
`define EFLAGS_SF_BIT 7
`define EFLAGS_DF_BIT 10
`define EFLAGS_OF_BIT 11
// Only reserved bit 1 set out of reset
`define EFLAGS_RESET  32'h0000_0002

`endif

/* hdl/alu_execute.sv */
//----------------------------------------------------------------------------
// ALU execute
// Combinational datapath: result, flag values and flag update mask
// for ADD, OR, NOT, DAA, AND, CLD, CMP and STD
//----------------------------------------------------------------------------
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_execute (
	input  alu_pkg::decoded_op_t dec,
	output alu_pkg::exec_out_t   exe
);
	import alu_pkg::*;

	// Flag masks
	localparam logic [31:0] of_mask    = 32'd1 << `EFLAGS_OF_BIT;
	localparam logic [31:0] arith_mask = of_mask |
		(32'd1 << `EFLAGS_SF_BIT) | (32'd1 << `EFLAGS_ZF_BIT) |
		(32'd1 << `EFLAGS_AF_BIT) | (32'd1 << `EFLAGS_PF_BIT) |
		(32'd1 << `EFLAGS_CF_BIT);
	// DAA leaves OF alone
	localparam logic [31:0] daa_mask   = arith_mask & ~of_mask;
	localparam logic [31:0] df_mask    = 32'd1 << `EFLAGS_DF_BIT;

	// One BCD digit plus carry in, returns {carry, digit}
	function automatic logic [4:0] daa_digit(input logic [3:0] digit, input logic carry_in);
		logic [4:0] sum;
		sum = {1'b0, digit} + {4'd0, carry_in};
		if (sum > 5'd9)
			daa_digit = {1'b1, sum[3:0] + 4'd6};
		else
			daa_digit = {1'b0, sum[3:0]};
	endfunction

	logic [32:0] add_sum;
	logic [32:0] sub_diff;
	logic        add_of;
	logic        sub_of;
	logic        add_af;
	logic        sub_af;
	logic [4:0]  daa_lo;
	logic [4:0]  daa_hi;
	logic [7:0]  daa_byte;
	logic        daa_carry;
	logic [31:0] res;
	eflags_u     flags;
	logic [31:0] mask;
	logic        wr;

	//------------------------------------------------------------------------
	// Adder and subtractor, 33 bits for carry and borrow
	assign add_sum  = {1'b0, dec.a} + {1'b0, dec.b};
	assign sub_diff = {1'b0, dec.a} - {1'b0, dec.b};
	// Carry into bit 4 is the nibble carry
	assign add_af   = dec.a[4] ^ dec.b[4] ^ add_sum[4];
	assign sub_af   = dec.a[4] ^ dec.b[4] ^ sub_diff[4];
	// Signed overflow from sign bits
	assign add_of   = (dec.a[31] == dec.b[31]) && (add_sum[31] != dec.a[31]);
	assign sub_of   = (dec.a[31] != dec.b[31]) && (sub_diff[31] != dec.a[31]);

	// DAA, low digit first, its carry feeds the high digit
	assign daa_lo    = daa_digit(dec.a[3:0], 1'b0);
	assign daa_hi    = daa_digit(dec.a[7:4], daa_lo[4]);
	assign daa_byte  = {daa_hi[3:0], daa_lo[3:0]};
	assign daa_carry = daa_lo[4] | daa_hi[4];

	//------------------------------------------------------------------------
	// Result and flag select
	always_comb begin
		res        = 32'd0;
		flags.word = 32'd0;
		mask       = 32'd0;
		wr         = 1'b0;
		case (dec.op)
			op_add: begin
				res           = add_sum[31:0];
				flags.bits.of = add_of;
				flags.bits.af = add_af;
				flags.bits.cf = add_sum[32];
				mask          = arith_mask;
				wr            = 1'b1;
			end
			op_or: begin
				// OF, AF, CF stay zero
				res  = dec.a | dec.b;
				mask = arith_mask;
				wr   = 1'b1;
			end
			op_not: begin
				// No flags change on NOT
				res = ~dec.a;
				wr  = 1'b1;
			end
			op_daa: begin
				res           = {dec.a[31:8], daa_byte};
				flags.bits.af = daa_carry;
				flags.bits.cf = daa_carry;
				mask          = daa_mask;
				wr            = 1'b1;
			end
			op_and: begin
				res  = dec.a & dec.b;
				mask = arith_mask;
				wr   = 1'b1;
			end
			op_cld: mask = df_mask;
			op_cmp: begin
				// a - b, result kept but not written back
				res           = sub_diff[31:0];
				flags.bits.of = sub_of;
				flags.bits.af = sub_af;
				flags.bits.cf = sub_diff[32];
				mask          = arith_mask;
			end
			op_std: begin
				flags.bits.df = 1'b1;
				mask          = df_mask;
			end
		endcase
		// Shared status flags, DAA looks at the adjusted byte only
		flags.bits.pf = ~^res[7:0];
		flags.bits.sf = (dec.op == op_daa) ? res[7] : res[31];
		flags.bits.zf = (dec.op == op_daa) ? (res[7:0] == 8'd0) : (res == 32'd0);
	end

	assign exe = '{valid: dec.valid, illegal: dec.illegal, write: wr && !dec.illegal,
		result: res, flag_val: flags, flag_mask: mask};

endmodule

/* hdl/alu_pkg.sv */
//----------------------------------------------------------------------------
// ALU package
// Operation encoding, stage payloads and the EFLAGS word
//----------------------------------------------------------------------------
package alu_pkg;

	// Select encoding of the ALU op mux
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_or  = 3'd1,
		op_not = 3'd2,
		op_daa = 3'd3,
		op_and = 3'd4,
		op_cld = 3'd5,
		op_cmp = 3'd6,
		op_std = 3'd7
	} alu_op_e;

	// Decode stage output
	typedef struct packed {
		logic        valid;
		logic        illegal;
		alu_op_e     op;
		logic [31:0] a;
		logic [31:0] b;
	} decoded_op_t;

	// x86 EFLAGS with the low 12 bits named
	typedef struct packed {
		logic [19:0] rsvd_hi;
		logic        of;
		logic        df;
		// TF and IF are never touched here
		logic [1:0]  rsvd_tf_if;
		logic        sf;
		logic        zf;
		logic        rsvd_5;
		logic        af;
		logic        rsvd_3;
		logic        pf;
		logic        rsvd_1;
		logic        cf;
	} eflags_bits_t;

	// Whole word for merging and fields for flag logic
	typedef union packed {
		logic [31:0]  word;
		eflags_bits_t bits;
	} eflags_u;

	// Execute stage output
	typedef struct packed {
		logic        valid;
		logic        illegal;
		logic        write;
		logic [31:0] result;
		eflags_u     flag_val;
		// 1 = bit updated
		logic [31:0] flag_mask;
	} exec_out_t;

endpackage

/* hdl/alu_result.sv */
//----------------------------------------------------------------------------
// ALU result stage
// Write-back register, architectural EFLAGS with masked merge,
// valid, write and illegal pulses
//----------------------------------------------------------------------------
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_result (
	input  logic               clk,
	input  logic               reset,
	input  alu_pkg::exec_out_t exe,
	output logic               result_valid,
	output logic               result_write,
	output logic [31:0]        result,
	output logic               illegal_op,
	output alu_pkg::eflags_u   eflags
);
	import alu_pkg::*;

	eflags_u flags_next;
	logic    retire;

	// Only legal ops touch EFLAGS
	assign retire = exe.valid && !exe.illegal;

	// Masked bits from execute, the rest held
	assign flags_next.word = (eflags.word & ~exe.flag_mask) |
		(exe.flag_val.word & exe.flag_mask);

	//------------------------------------------------------------------------
	// Output pulses and write-back data
	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			result_write <= 1'b0;
			illegal_op   <= 1'b0;
			result       <= 32'd0;
		end else begin
			// One cycle per retired instruction
			result_valid <= exe.valid;
			result_write <= exe.valid && exe.write;
			illegal_op   <= exe.valid && exe.illegal;
			if (exe.valid)
				result <= exe.result;
		end
	end

	//------------------------------------------------------------------------
	// Architectural EFLAGS
	always_ff @(posedge clk) begin
		if (reset)
			eflags.word <= `EFLAGS_RESET;
		else if (retire)
			eflags <= flags_next;
	end

endmodule

/* hdl/alu_top.sv */
//----------------------------------------------------------------------------
// ALU top
// Decode, execute and result stages, two-edge latency
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module alu_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  logic [7:0]  opcode,
	input  logic [2:0]  modrm_reg,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic        result_valid,
	output logic        result_write,
	output logic [31:0] result,
	output logic        illegal_op,
	output logic [31:0] eflags
);
	import alu_pkg::*;

	// Stage payloads
	decoded_op_t dec;
	exec_out_t   exe;

	// Registered decode, edge N
	alu_decode u_alu_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.opcode      (opcode),
		.modrm_reg   (modrm_reg),
		.a           (a),
		.b           (b),
		.dec         (dec)
	);

	// Pure logic between the two registers
	alu_execute u_alu_execute (
		.dec (dec),
		.exe (exe)
	);

	// Write-back and EFLAGS, edge N+1
	alu_result u_alu_result (
		.clk          (clk),
		.reset        (reset),
		.exe          (exe),
		.result_valid (result_valid),
		.result_write (result_write),
		.result       (result),
		.illegal_op   (illegal_op),
		.eflags       (eflags)
	);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb \
	-f compile.f -o alu_sim

# Keep going past assertion errors, the log decides
./obj_dir/alu_sim +verilator+error+limit+100000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
grep -q "TEST OK" sim.log

/* verif/alu_checker.sv */
//----------------------------------------------------------------------------
// ALU checker
// Bound to the ALU top. Shadows each instruction for two edges and
// checks latency, write control, results and EFLAGS against a model
//----------------------------------------------------------------------------
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_checker (
	input logic        clk,
	input logic        reset,
	input logic        instr_valid,
	input logic [7:0]  opcode,
	input logic [2:0]  modrm_reg,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic        result_valid,
	input logic        result_write,
	input logic [31:0] result,
	input logic        illegal_op,
	input logic [31:0] eflags
);

	int unsigned err_count;

	// Two-deep instruction shadow
	logic        vld_d1;
	logic        vld_d2;
	logic [7:0]  op_d1;
	logic [7:0]  op_d2;
	logic [2:0]  reg_d1;
	logic [2:0]  reg_d2;
	logic [31:0] a_d1;
	logic [31:0] a_d2;
	logic [31:0] b_d1;
	logic [31:0] b_d2;
	logic        exp_legal;
	logic        exp_write;
	logic [31:0] exp_result;
	logic [31:0] exp_eflags;

	//------------------------------------------------------------------------
	// Reference model

	// Packed BCD fix of one byte as {nibble carry, byte}
	function automatic logic [8:0] daa_model(input logic [7:0] v);
		logic [4:0] lo;
		logic [4:0] hi;
		logic       c_lo;
		logic       c_hi;
		lo   = {1'b0, v[3:0]};
		c_lo = (lo > 5'd9);
		if (c_lo)
			lo = lo + 5'd6;
		hi   = {1'b0, v[7:4]} + {4'd0, c_lo};
		c_hi = (hi > 5'd9);
		if (c_hi)
			hi = hi + 5'd6;
		return {c_lo | c_hi, hi[3:0], lo[3:0]};
	endfunction

	function automatic logic legal_model(input logic [7:0] opc, input logic [2:0] rg);
		case (opc)
			`ALU_OP_ADD, `ALU_OP_OR, `ALU_OP_AND, `ALU_OP_CMP,
			`ALU_OP_DAA, `ALU_OP_CLD, `ALU_OP_STD: return 1'b1;
			`ALU_OP_GRP3: return (rg == `ALU_MODRM_NOT);
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] result_model(input logic [7:0] opc,
		input logic [31:0] av, input logic [31:0] bv);
		logic [8:0] adj;
		adj = daa_model(av[7:0]);
		case (opc)
			`ALU_OP_ADD:  return av + bv;
			`ALU_OP_OR:   return av | bv;
			`ALU_OP_AND:  return av & bv;
			`ALU_OP_CMP:  return av - bv;
			`ALU_OP_GRP3: return ~av;
			`ALU_OP_DAA:  return {av[31:8], adj[7:0]};
			default:      return 32'd0;
		endcase
	endfunction

	// New EFLAGS word from the old one
	function automatic logic [31:0] flags_model(input logic [31:0] old,
		input logic [7:0] opc, input logic [31:0] av, input logic [31:0] bv);
		logic [31:0] f;
		logic [31:0] r;
		logic [32:0] wide;
		logic [4:0]  nib;
		logic [8:0]  adj;
		logic        status;
		f      = old;
		r      = result_model(opc, av, bv);
		adj    = daa_model(av[7:0]);
		status = 1'b1;
		case (opc)
			`ALU_OP_ADD: begin
				wide = {1'b0, av} + {1'b0, bv};
				nib  = {1'b0, av[3:0]} + {1'b0, bv[3:0]};
				f[`EFLAGS_CF_BIT] = wide[32];
				f[`EFLAGS_AF_BIT] = nib[4];
				f[`EFLAGS_OF_BIT] = (av[31] == bv[31]) && (r[31] != av[31]);
			end
			`ALU_OP_CMP: begin
				// Borrow means a below b as unsigned
				f[`EFLAGS_CF_BIT] = (av < bv);
				f[`EFLAGS_AF_BIT] = (av[3:0] < bv[3:0]);
				f[`EFLAGS_OF_BIT] = (av[31] != bv[31]) && (r[31] != av[31]);
			end
			`ALU_OP_OR, `ALU_OP_AND: begin
				f[`EFLAGS_CF_BIT] = 1'b0;
				f[`EFLAGS_AF_BIT] = 1'b0;
				f[`EFLAGS_OF_BIT] = 1'b0;
			end
			`ALU_OP_DAA: begin
				// Byte-wide status with OF kept
				f[`EFLAGS_CF_BIT] = adj[8];
				f[`EFLAGS_AF_BIT] = adj[8];
				f[`EFLAGS_PF_BIT] = ~^adj[7:0];
				f[`EFLAGS_ZF_BIT] = (adj[7:0] == 8'd0);
				f[`EFLAGS_SF_BIT] = adj[7];
				status = 1'b0;
			end
			`ALU_OP_CLD: begin
				f[`EFLAGS_DF_BIT] = 1'b0;
				status = 1'b0;
			end
			`ALU_OP_STD: begin
				f[`EFLAGS_DF_BIT] = 1'b1;
				status = 1'b0;
			end
			// NOT and unknown opcodes leave every flag
			default: status = 1'b0;
		endcase
		if (status) begin
			f[`EFLAGS_PF_BIT] = ~^r[7:0];
			f[`EFLAGS_ZF_BIT] = (r == 32'd0);
			f[`EFLAGS_SF_BIT] = r[31];
		end
		return f;
	endfunction

	//------------------------------------------------------------------------
	// Shadow pipeline and expected values
	always_ff @(posedge clk) begin
		vld_d1    <= instr_valid;
		vld_d2    <= vld_d1;
		op_d1     <= opcode;
		op_d2     <= op_d1;
		reg_d1    <= modrm_reg;
		reg_d2    <= reg_d1;
		a_d1      <= a;
		a_d2      <= a_d1;
		b_d1      <= b;
		b_d2      <= b_d1;
	end

	// Model EFLAGS, updated on the same edge as the DUT register
	always_ff @(posedge clk) begin
		if (reset)
			exp_eflags <= `EFLAGS_RESET;
		// Illegal ops and idle cycles hold EFLAGS
		else if (vld_d1 && legal_model(op_d1, reg_d1))
			exp_eflags <= flags_model(exp_eflags, op_d1, a_d1, b_d1);
	end

	initial err_count = 0;

	assign exp_legal  = legal_model(op_d2, reg_d2);
	assign exp_write  = exp_legal && (op_d2 != `ALU_OP_CMP) &&
		(op_d2 != `ALU_OP_CLD) && (op_d2 != `ALU_OP_STD);
	assign exp_result = result_model(op_d2, a_d2, b_d2);

	//------------------------------------------------------------------------
	// Assertions
	a_reset: assert property (@(posedge clk) $past(reset) |->
		(!result_valid && !result_write && !illegal_op && eflags == `EFLAGS_RESET))
	else begin
		$error("Outputs not at their reset values after reset");
		err_count++;
	end

	// Fixed two-edge latency
	a_latency: assert property (@(posedge clk) disable iff (reset)
		result_valid == vld_d2)
	else begin
		$error("Mismatch result_valid: got %h expected %h",
			$sampled(result_valid), $sampled(vld_d2));
		err_count++;
	end

	a_pulses: assert property (@(posedge clk) disable iff (reset)
		!result_valid |-> (!result_write && !illegal_op))
	else begin
		$error("Write or illegal pulse without result_valid");
		err_count++;
	end

	a_write: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> (result_write == exp_write))
	else begin
		$error("Mismatch result_write: got %h expected %h",
			$sampled(result_write), $sampled(exp_write));
		err_count++;
	end

	a_illegal: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> (illegal_op == !exp_legal))
	else begin
		$error("Mismatch illegal_op: got %h expected %h",
			$sampled(illegal_op), $sampled(!exp_legal));
		err_count++;
	end

	a_result: assert property (@(posedge clk) disable iff (reset)
		result_write |-> (result == exp_result))
	else begin
		$error("Mismatch result: got %h expected %h",
			$sampled(result), $sampled(exp_result));
		err_count++;
	end

	a_eflags: assert property (@(posedge clk) disable iff (reset)
		eflags == exp_eflags)
	else begin
		$error("Mismatch eflags: got %h expected %h",
			$sampled(eflags), $sampled(exp_eflags));
		err_count++;
	end

endmodule

/* verif/alu_tb.sv */
//----------------------------------------------------------------------------
// ALU testbench
// Directed and random instruction streams, bound checker does the checks
//----------------------------------------------------------------------------
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_tb;

	logic        clk;
	logic        reset;
	logic        instr_valid;
	logic [7:0]  opcode;
	logic [2:0]  modrm_reg;
	logic [31:0] a;
	logic [31:0] b;
	logic        result_valid;
	logic        result_write;
	logic [31:0] result;
	logic        illegal_op;
	logic [31:0] eflags;

	integer      seed;
	int unsigned issued;
	int unsigned retired;
	int unsigned err_base;
	int unsigned tests_run;
	int unsigned tests_failed;
	int unsigned timeouts;
	logic [7:0]  op_list [8];
	logic [31:0] r;

	alu_top alu_top_i (.*);

	bind alu_top alu_checker alu_checker_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Result pulses seen so far
	always @(posedge clk) begin
		if (reset)
			retired <= 0;
		else if (result_valid)
			retired <= retired + 1;
	end

	//------------------------------------------------------------------------
	// Stimulus helpers, all entered on a falling edge

	task automatic issue(input logic [7:0] opc, input logic [2:0] rg,
		input logic [31:0] av, input logic [31:0] bv);
		instr_valid = 1'b1;
		opcode      = opc;
		modrm_reg   = rg;
		a           = av;
		b           = bv;
		issued++;
		@(negedge clk);
	endtask

	// Drain the pipe, then report the test
	task automatic end_test(input string name);
		int unsigned wait_cycles;
		int unsigned errs;
		logic        timed_out;
		wait_cycles = 0;
		instr_valid = 1'b0;
		while (retired != issued && wait_cycles < 20) begin
			@(negedge clk);
			wait_cycles++;
		end
		timed_out = (retired != issued);
		if (timed_out) begin
			$display("%s: timed out waiting for result_valid, %0d of %0d results seen",
				name, retired, issued);
			timeouts++;
		end
		@(negedge clk);
		errs = alu_top_i.alu_checker_i.err_count - err_base;
		err_base = alu_top_i.alu_checker_i.err_count;
		tests_run++;
		if (errs != 0 || timed_out)
			tests_failed++;
		$display("%s: %0d instructions, %0d assertion failures, %s", name, issued, errs,
			(errs != 0 || timed_out) ? "failed" : "passed");
		issued  = 0;
		retired = 0;
	endtask

	//------------------------------------------------------------------------
	// Test sequence
	initial begin
		seed         = 32'h1a07;
		reset        = 1'b1;
		instr_valid  = 1'b0;
		opcode       = 8'h00;
		modrm_reg    = 3'd0;
		a            = 32'd0;
		b            = 32'd0;
		issued       = 0;
		err_base     = 0;
		tests_run    = 0;
		tests_failed = 0;
		timeouts     = 0;
		op_list = '{`ALU_OP_ADD, `ALU_OP_OR, `ALU_OP_AND, `ALU_OP_CMP,
			`ALU_OP_DAA, `ALU_OP_CLD, `ALU_OP_STD, `ALU_OP_GRP3};
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		end_test("reset");

		// Mostly back to back, an idle cycle now and then
		for (int i = 0; i < 48; i++) begin
			r = $random(seed);
			issue(op_list[r[2:0]], r[5:3], $random(seed), $random(seed));
			if (r[7:6] == 2'b11) begin
				instr_valid = 1'b0;
				@(negedge clk);
			end
		end
		end_test("latency");

		issue(`ALU_OP_ADD, 3'd0, 32'h0000_0000, 32'h0000_0000);
		issue(`ALU_OP_ADD, 3'd0, 32'h7FFF_FFFF, 32'h0000_0001);
		issue(`ALU_OP_ADD, 3'd0, 32'hFFFF_FFFF, 32'h0000_0001);
		issue(`ALU_OP_CMP, 3'd0, 32'h0000_0005, 32'h0000_0005);
		issue(`ALU_OP_CMP, 3'd0, 32'h0000_0000, 32'h0000_0001);
		issue(`ALU_OP_CMP, 3'd0, 32'h8000_0000, 32'h0000_0001);
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			issue(r[0] ? `ALU_OP_CMP : `ALU_OP_ADD, 3'd0, $random(seed), $random(seed));
		end
		end_test("arithmetic");

		for (int i = 0; i < 48; i++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0: issue(`ALU_OP_OR, 3'd0, $random(seed), $random(seed));
				2'd1: issue(`ALU_OP_AND, 3'd0, $random(seed), $random(seed));
				default: issue(`ALU_OP_GRP3, `ALU_MODRM_NOT, $random(seed), $random(seed));
			endcase
		end
		end_test("logic");

		// Every low byte, random upper bits
		for (int i = 0; i < 256; i++) begin
			r = $random(seed);
			issue(`ALU_OP_DAA, 3'd0, {r[31:8], i[7:0]}, $random(seed));
		end
		end_test("daa");

		issue(`ALU_OP_STD, 3'd0, 32'd0, 32'd0);
		issue(`ALU_OP_ADD, 3'd0, $random(seed), $random(seed));
		issue(`ALU_OP_OR, 3'd0, $random(seed), $random(seed));
		issue(`ALU_OP_GRP3, `ALU_MODRM_NOT, $random(seed), 32'd0);
		issue(`ALU_OP_DAA, 3'd0, 32'h0000_009A, 32'd0);
		issue(`ALU_OP_CLD, 3'd0, 32'd0, 32'd0);
		issue(`ALU_OP_AND, 3'd0, $random(seed), $random(seed));
		issue(`ALU_OP_STD, 3'd0, 32'd0, 32'd0);
		issue(`ALU_OP_CMP, 3'd0, $random(seed), $random(seed));
		// Unknown opcodes and other group 3 members
		issue(8'h00, 3'd0, $random(seed), $random(seed));
		issue(8'h90, 3'd0, $random(seed), $random(seed));
		issue(`ALU_OP_GRP3, 3'd0, $random(seed), $random(seed));
		issue(`ALU_OP_GRP3, 3'd3, $random(seed), $random(seed));
		issue(`ALU_OP_GRP3, 3'd7, $random(seed), $random(seed));
		issue(8'hFF, 3'd2, $random(seed), $random(seed));
		issue(`ALU_OP_CLD, 3'd0, 32'd0, 32'd0);
		issue(`ALU_OP_ADD, 3'd0, $random(seed), $random(seed));
		end_test("direction_and_illegal");

		$display("Tests run %0d, failed %0d, assertion failures %0d, timeouts %0d",
			tests_run, tests_failed, alu_top_i.alu_checker_i.err_count, timeouts);
		if (tests_failed == 0 && alu_top_i.alu_checker_i.err_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
